// ==== vlog.f ====
+incdir+.
scan_pkg.sv
uart_rx.sv
scan_parser.sv
angle_divider.sv
scan_angle_calc.sv
report_tx.sv
scan_top.sv
scan_sva.sv
tb_scan.sv

// ==== Bender.yml ====
package:
  name: scan_proc

export_include_dirs:
  - .

sources:
  - scan_pkg.sv
  - uart_rx.sv
  - scan_parser.sv
  - angle_divider.sv
  - scan_angle_calc.sv
  - report_tx.sv
  - scan_top.sv
  - target: test
    files:
      - scan_sva.sv
      - tb_scan.sv

// ==== tb_scan.sv ====
`timescale 1ns/1ps
`include "scan_cfg.svh"
`default_nettype none

module tb_scan;

    import scan_pkg::*;

    localparam int BIT_CYCLES  = `SCAN_CLKS_PER_BIT;
    localparam int NUM_PACKETS = 14;
    // report starts a few dozen cycles after the last stop bit
    localparam int START_LIMIT = 40 * BIT_CYCLES;
    localparam int END_LIMIT   = 3 * BIT_CYCLES;

    logic clk = 1'b0;
    logic TxD_reset;
    logic rx_serial;
    logic tx_serial;
    logic tx_busy;

    logic [15:0] lfsr_q = 16'd38951;
    distance_t   samples [0:255];
    int unsigned mismatches = 0;
    int unsigned protocol_errors = 0;
    int unsigned timeouts = 0;
    int unsigned busy_rises = 0;
    logic        busy_prev = 1'b0;

    scan_top dut_i (
        .clk       (clk),
        .TxD_reset (TxD_reset),
        .rx_serial (rx_serial),
        .tx_serial (tx_serial),
        .tx_busy   (tx_busy)
    );

    // 50 MHz
    always #10 clk = ~clk;

    // each report shows up as one rising tx_busy
    always @(negedge clk) begin
        if (tx_busy && !busy_prev) begin
            busy_rises = busy_rises + 1;
        end
        busy_prev = tx_busy;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // reference model straight from the packet rules
    function automatic scan_report_t expected_report(input int ct, input angle_t fsa,
                                                     input angle_t lsa);
        scan_report_t rep;
        distance_t    lo_val;
        distance_t    hi_val;
        logic [31:0]  lo_idx;
        logic [31:0]  hi_idx;
        logic [15:0]  mask;
        logic [31:0]  span;
        int           i;
        lo_val = 16'hFFFF;
        hi_val = 16'h0000;
        lo_idx = '0;
        hi_idx = '0;
        mask   = '0;
        for (i = 0; i < ct; i++) begin
            // zero means no return, skip it
            if (samples[i] != 16'h0000) begin
                if (samples[i] < lo_val) begin
                    lo_val = samples[i];
                    lo_idx = 32'(i);
                end
                if (samples[i] > hi_val) begin
                    hi_val = samples[i];
                    hi_idx = 32'(i);
                end
                if (i < `SCAN_ALERT_SAMPLES) begin
                    mask = {samples[i] < `SCAN_OBS_DISTANCE, mask[15:1]};
                end
            end
        end
        span          = {16'd0, angle_t'(lsa - fsa)};
        rep.alert     = mask;
        rep.min_angle = angle_t'({16'd0, fsa} + lo_idx * span / 32'(ct - 1));
        rep.max_angle = angle_t'({16'd0, fsa} + hi_idx * span / 32'(ct - 1));
        return rep;
    endfunction

    task automatic check_alert(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("FAILED %s: expected %04h, actual %04h", name, exp, act);
        end
    endtask

    task automatic check_angle(input string name, input angle_t exp, input angle_t act);
        if (act !== exp) begin
            mismatches++;
            $display("FAILED %s: expected %04h, actual %04h", name, exp, act);
        end
    endtask

    task automatic send_bit(input logic v);
        @(posedge clk);
        rx_serial <= v;
        repeat (BIT_CYCLES - 1) @(posedge clk);
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] b);
        int i;
        send_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            send_bit(b[i]);
        end
        send_bit(1'b1);
    endtask

    task automatic send_word(input logic [15:0] w);
        send_byte(w[7:0]);
        send_byte(w[15:8]);
    endtask

    // decode one frame from tx_serial, sampled mid-bit on falling edges
    task automatic receive_byte(output logic [7:0] b, output bit ok);
        int waited;
        int i;
        ok     = 1'b1;
        b      = '0;
        waited = 0;
        @(negedge clk);
        while (tx_serial !== 1'b0 && waited < START_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_serial !== 1'b0) begin
            timeouts++;
            ok = 1'b0;
            $display("timeout: no start bit on tx_serial");
        end else begin
            repeat (BIT_CYCLES / 2) @(negedge clk);
            if (tx_serial !== 1'b0) begin
                protocol_errors++;
                $display("start bit on tx_serial did not last to mid-bit");
            end
            for (i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(negedge clk);
                b[i] = tx_serial;
            end
            repeat (BIT_CYCLES) @(negedge clk);
            if (tx_serial !== 1'b1) begin
                protocol_errors++;
                $display("stop bit on tx_serial was low");
            end
        end
    endtask

    // junk, one packet, then the six report frames
    task automatic run_packet(input int k, input int ct, input bit all_zero);
        angle_t       a;
        angle_t       b;
        angle_t       fsa;
        angle_t       lsa;
        scan_report_t exp;
        logic [7:0]   got [0:5];
        logic [7:0]   j;
        logic [3:0]   sel;
        bit           ok;
        int           n_junk;
        int           i;
        int           waited;
        int unsigned  rises_before;
        rises_before = busy_rises;
        n_junk       = int'(rand_bits(2));
        // junk never holds a header byte
        for (i = 0; i < n_junk; i++) begin
            j = 8'(rand_bits(8));
            if (j == `SCAN_HEADER_A) begin
                j = 8'h3C;
            end
            send_byte(j);
        end
        // broken header, first byte without the second
        if (rand_bits(1) != 0) begin
            send_byte(`SCAN_HEADER_A);
            j = 8'(rand_bits(8));
            if (j == `SCAN_HEADER_A || j == `SCAN_HEADER_B) begin
                j = 8'h00;
            end
            send_byte(j);
        end
        repeat (3 * BIT_CYCLES) @(posedge clk);
        if (busy_rises != rises_before) begin
            protocol_errors++;
            $display("packet %0d: junk bytes produced a report", k);
        end
        a   = angle_t'(rand_bits(16));
        b   = angle_t'(rand_bits(16));
        fsa = (a < b) ? a : b;
        lsa = (a < b) ? b : a;
        // small value sets so ties come up often
        for (i = 0; i < ct; i++) begin
            sel = 4'(rand_bits(4));
            if (all_zero || sel < 4'd4) begin
                samples[i] = 16'h0000;
            end else if (sel < 4'd9) begin
                samples[i] = distance_t'(8 * (1 + rand_bits(3)));
            end else begin
                samples[i] = distance_t'((1 + rand_bits(3)) << 8);
            end
        end
        exp = expected_report(ct, fsa, lsa);
        send_byte(`SCAN_HEADER_A);
        send_byte(`SCAN_HEADER_B);
        send_byte(8'(ct));
        send_word(fsa);
        send_word(lsa);
        for (i = 0; i < ct; i++) begin
            send_word(samples[i]);
        end
        ok = 1'b1;
        for (i = 0; i < 6 && ok; i++) begin
            receive_byte(got[i], ok);
        end
        if (ok) begin
            check_alert($sformatf("packet %0d alert", k), exp.alert, {got[1], got[0]});
            check_angle($sformatf("packet %0d min angle", k), exp.min_angle,
                        {got[3], got[2]});
            check_angle($sformatf("packet %0d max angle", k), exp.max_angle,
                        {got[5], got[4]});
        end
        // busy must drop right after the sixth stop bit
        waited = 0;
        while (tx_busy !== 1'b0 && waited < END_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_busy !== 1'b0) begin
            timeouts++;
            $display("packet %0d: timeout, tx_busy stayed high after six frames", k);
        end else if (busy_rises != rises_before + 1) begin
            protocol_errors++;
            $display("packet %0d: expected one report, saw %0d", k,
                     busy_rises - rises_before);
        end
    endtask

    initial begin
        int          k;
        int          ct;
        int unsigned sva_fails;
        TxD_reset = 1'b1;
        rx_serial = 1'b1;
        repeat (4) @(posedge clk);
        TxD_reset <= 1'b0;
        repeat (2 * BIT_CYCLES) @(posedge clk);
        for (k = 0; k < NUM_PACKETS; k++) begin
            // longest and shortest packets first, then random
            if (k == 0) begin
                ct = 20;
            end else if (k == 1) begin
                ct = 2;
            end else begin
                ct = 2 + int'(rand_bits(5) % 19);
            end
            run_packet(k, ct, (k == 2) || (k == 9));
        end
        sva_fails = dut_i.scan_sva_i.fail_count;
        $display("errors: %0d mismatches, %0d protocol, %0d timeouts, %0d assertions",
                 mismatches, protocol_errors, timeouts, sva_fails);
        if (mismatches + protocol_errors + timeouts + sva_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== scan_sva.sv ====
`timescale 1ns/1ps
`include "scan_cfg.svh"
`default_nettype none

module scan_sva (
    input logic clk,
    input logic TxD_reset,
    input logic rx_serial,
    input logic tx_serial,
    input logic tx_busy
);

    // six frames of ten bits, one bit of slack
    localparam int BUSY_LIMIT = 61 * `SCAN_CLKS_PER_BIT;

    int unsigned fail_count = 0;
    logic        quiet_q;
    logic [15:0] busy_len_q;

    // set until the receive line first drops after reset
    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            quiet_q <= 1'b1;
        end else if (!rx_serial) begin
            quiet_q <= 1'b0;
        end
    end

    // length of the current send
    always_ff @(posedge clk) begin
        if (TxD_reset || !tx_busy) begin
            busy_len_q <= '0;
        end else begin
            busy_len_q <= busy_len_q + 16'd1;
        end
    end

    idle_line_high: assert property (@(posedge clk) disable iff (TxD_reset)
        !tx_busy |-> tx_serial)
        else begin
            fail_count++;
            $error("tx_serial low while transmitter idle");
        end

    quiet_rx_no_tx: assert property (@(posedge clk) disable iff (TxD_reset)
        quiet_q |-> !tx_busy)
        else begin
            fail_count++;
            $error("tx_busy rose without any receive traffic");
        end

    busy_bounded: assert property (@(posedge clk) disable iff (TxD_reset)
        tx_busy |-> (busy_len_q < 16'(BUSY_LIMIT)))
        else begin
            fail_count++;
            $error("tx_busy held longer than six frames");
        end

endmodule

bind scan_top scan_sva scan_sva_i (
    .clk       (clk),
    .TxD_reset (TxD_reset),
    .rx_serial (rx_serial),
    .tx_serial (tx_serial),
    .tx_busy   (tx_busy)
);

`default_nettype wire

// ==== scan_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_top (
    input  logic clk,
    input  logic TxD_reset,
    input  logic rx_serial,
    output logic tx_serial,
    output logic tx_busy
);

    import scan_pkg::*;

    logic [7:0]    rx_byte;
    logic          rx_valid;
    scan_summary_t summary;
    logic          summary_valid;
    logic [15:0]   alert;
    logic          alert_valid;
    scan_report_t  report;
    logic          report_valid;

    uart_rx uart_rx_i (
        .clk       (clk),
        .TxD_reset (TxD_reset),
        .rx_serial (rx_serial),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    // one packet at a time into a summary
    scan_parser scan_parser_i (
        .clk           (clk),
        .TxD_reset     (TxD_reset),
        .rx_byte       (rx_byte),
        .rx_valid      (rx_valid),
        .summary       (summary),
        .summary_valid (summary_valid),
        .alert         (alert),
        .alert_valid   (alert_valid)
    );

    scan_angle_calc scan_angle_calc_i (
        .clk           (clk),
        .TxD_reset     (TxD_reset),
        .summary       (summary),
        .summary_valid (summary_valid),
        .alert         (alert),
        .alert_valid   (alert_valid),
        .report        (report),
        .report_valid  (report_valid)
    );

    report_tx report_tx_i (
        .clk          (clk),
        .TxD_reset    (TxD_reset),
        .report       (report),
        .report_valid (report_valid),
        .tx_serial    (tx_serial),
        .tx_busy      (tx_busy)
    );

endmodule

`default_nettype wire

// ==== report_tx.sv ====
`timescale 1ns/1ps
`include "scan_cfg.svh"
`default_nettype none

module report_tx (
    input  logic                   clk,
    input  logic                   TxD_reset,
    input  scan_pkg::scan_report_t report,
    input  logic                   report_valid,
    output logic                   tx_serial,
    output logic                   tx_busy
);

    import scan_pkg::*;

    localparam int FULL = `SCAN_CLKS_PER_BIT;

    scan_report_t rep_q;
    logic         busy_q;
    logic [2:0]   byte_q;
    logic [3:0]   bit_q;
    logic [9:0]   cnt_q;
    logic [9:0]   frame_q;

    logic         latch;
    logic         bit_end;
    logic         frame_end;
    logic         next_frame;

    // six bytes, each field low byte first
    function automatic logic [7:0] pick_byte(scan_report_t r, logic [2:0] i);
        case (i)
            3'd0:    pick_byte = r.alert[7:0];
            3'd1:    pick_byte = r.alert[15:8];
            3'd2:    pick_byte = r.min_angle[7:0];
            3'd3:    pick_byte = r.min_angle[15:8];
            3'd4:    pick_byte = r.max_angle[7:0];
            default: pick_byte = r.max_angle[15:8];
        endcase
    endfunction

    // reports during a send are dropped
    assign latch      = report_valid && !busy_q;
    assign bit_end    = busy_q && (cnt_q == 10'(FULL - 1));
    assign frame_end  = bit_end && (bit_q == 4'd9);
    assign next_frame = frame_end && (byte_q != 3'd5);

    // line idles high
    assign tx_serial = busy_q ? frame_q[0] : 1'b1;
    assign tx_busy   = busy_q;

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            busy_q <= 1'b0;
            byte_q <= '0;
            bit_q  <= '0;
            cnt_q  <= '0;
        end else if (latch) begin
            busy_q <= 1'b1;
            byte_q <= '0;
            bit_q  <= '0;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= bit_end ? 10'd0 : cnt_q + 10'd1;
            if (next_frame) begin
                // next start bit follows the stop bit directly
                byte_q <= byte_q + 3'd1;
                bit_q  <= '0;
            end else if (frame_end) begin
                busy_q <= 1'b0;
            end else if (bit_end) begin
                bit_q <= bit_q + 4'd1;
            end
        end
    end

    // frame is stop, data, start with the start bit at the bottom
    always_ff @(posedge clk) begin
        if (latch) begin
            rep_q   <= report;
            frame_q <= {1'b1, pick_byte(report, 3'd0), 1'b0};
        end else if (next_frame) begin
            frame_q <= {1'b1, pick_byte(rep_q, byte_q + 3'd1), 1'b0};
        end else if (bit_end) begin
            frame_q <= {1'b1, frame_q[9:1]};
        end
    end

endmodule

`default_nettype wire

// ==== scan_angle_calc.sv ====
`timescale 1ns/1ps
`include "scan_cfg.svh"
`default_nettype none

module scan_angle_calc (
    input  logic                    clk,
    input  logic                    TxD_reset,
    input  scan_pkg::scan_summary_t summary,
    input  logic                    summary_valid,
    input  logic [15:0]             alert,
    input  logic                    alert_valid,
    output scan_pkg::scan_report_t  report,
    output logic                    report_valid
);

    import scan_pkg::*;

    localparam int W = `SCAN_DIV_WIDTH;

    angle_t       span;
    angle_t       fsa_q;
    logic [15:0]  mask_q;
    logic [W-1:0] num_min_q;
    logic [W-1:0] num_max_q;
    logic [W-1:0] den_q;
    logic         start_q;
    logic [W-1:0] min_quo;
    logic [W-1:0] max_quo;
    logic         min_done;
    logic         max_done;
    logic         both_done;

    assign span = summary.lsa - summary.fsa;

    // index times span over count minus one
    always_ff @(posedge clk) begin
        if (summary_valid) begin
            fsa_q     <= summary.fsa;
            num_min_q <= W'(summary.min_idx) * W'(span);
            num_max_q <= W'(summary.max_idx) * W'(span);
            den_q     <= W'(summary.count - 8'd1);
        end
        if (alert_valid) begin
            mask_q <= alert;
        end
    end

    angle_divider min_div_i (
        .clk         (clk),
        .TxD_reset   (TxD_reset),
        .start       (start_q),
        .numerator   (num_min_q),
        .denominator (den_q),
        .quotient    (min_quo),
        .done        (min_done)
    );

    angle_divider max_div_i (
        .clk         (clk),
        .TxD_reset   (TxD_reset),
        .start       (start_q),
        .numerator   (num_max_q),
        .denominator (den_q),
        .quotient    (max_quo),
        .done        (max_done)
    );

    // shared start and fixed length, so both done pulses line up
    assign both_done = min_done && max_done;

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            start_q      <= 1'b0;
            report_valid <= 1'b0;
        end else begin
            start_q      <= summary_valid;
            report_valid <= both_done;
        end
    end

    always_ff @(posedge clk) begin
        if (both_done) begin
            report.alert     <= mask_q;
            report.min_angle <= fsa_q + angle_t'(min_quo);
            report.max_angle <= fsa_q + angle_t'(max_quo);
        end
    end

endmodule

`default_nettype wire

// ==== angle_divider.sv ====
`timescale 1ns/1ps
`include "scan_cfg.svh"
`default_nettype none

module angle_divider (
    input  logic                       clk,
    input  logic                       TxD_reset,
    input  logic                       start,
    input  logic [`SCAN_DIV_WIDTH-1:0] numerator,
    input  logic [`SCAN_DIV_WIDTH-1:0] denominator,
    output logic [`SCAN_DIV_WIDTH-1:0] quotient,
    output logic                       done
);

    localparam int W = `SCAN_DIV_WIDTH;

    logic         busy_q;
    logic [5:0]   cnt_q;
    logic [W-1:0] rem_q;
    logic [W-1:0] quo_q;
    logic [W-1:0] den_q;

    logic [W-1:0] rem_src;
    logic [W-1:0] quo_src;
    logic [W-1:0] den_src;
    logic [W:0]   rem_shift;
    logic         sub_ok;
    logic [W-1:0] rem_next;
    logic [W-1:0] quo_next;

    // start cycle already does the first step on the raw operands
    always_comb begin
        rem_src   = start ? '0 : rem_q;
        quo_src   = start ? numerator : quo_q;
        den_src   = start ? denominator : den_q;
        rem_shift = {rem_src, quo_src[W-1]};
        sub_ok    = (rem_shift >= {1'b0, den_src});
        // remainder stays below the divisor, top bit is always zero
        rem_next  = sub_ok ? W'(rem_shift - {1'b0, den_src}) : rem_shift[W-1:0];
        quo_next  = {quo_src[W-2:0], sub_ok};
    end

    assign quotient = quo_q;

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= 6'(W - 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 6'd1;
                // 32nd step lands here
                if (cnt_q == 6'd1) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy_q) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
        if (start) begin
            den_q <= denominator;
        end
    end

endmodule

`default_nettype wire

// ==== scan_parser.sv ====
`timescale 1ns/1ps
`include "scan_cfg.svh"
`default_nettype none

module scan_parser (
    input  logic                   clk,
    input  logic                   TxD_reset,
    input  logic [7:0]             rx_byte,
    input  logic                   rx_valid,
    output scan_pkg::scan_summary_t summary,
    output logic                   summary_valid,
    output logic [15:0]            alert,
    output logic                   alert_valid
);

    import scan_pkg::*;

    typedef enum logic [2:0] {
        HUNT_A, HUNT_B, GET_COUNT, GET_FSA, GET_LSA, GET_SAMPLE
    } parse_state_t;

    parse_state_t state_q;
    logic         hi_q;
    logic [7:0]   idx_q;
    logic [7:0]   lo_q;
    logic [7:0]   count_q;
    angle_t       fsa_q;
    angle_t       lsa_q;
    distance_t    min_q;
    distance_t    max_q;
    logic [7:0]   min_idx_q;
    logic [7:0]   max_idx_q;
    logic [15:0]  mask_q;

    distance_t    word;
    logic         nonzero;
    logic         take_min;
    logic         take_max;
    logic         shift_mask;
    logic [15:0]  mask_next;
    logic [7:0]   min_idx_next;
    logic [7:0]   max_idx_next;
    logic         last_sample;

    // little endian, low byte already held
    assign word       = {rx_byte, lo_q};
    assign nonzero    = (word != '0);
    // strict compares so the first occurrence stays
    assign take_min   = nonzero && (word < min_q);
    assign take_max   = nonzero && (word > max_q);
    assign shift_mask = nonzero && (idx_q < 8'(`SCAN_ALERT_SAMPLES));
    assign mask_next  = shift_mask ? {word < `SCAN_OBS_DISTANCE, mask_q[15:1]} : mask_q;
    assign min_idx_next = take_min ? idx_q : min_idx_q;
    assign max_idx_next = take_max ? idx_q : max_idx_q;
    assign last_sample  = rx_valid && (state_q == GET_SAMPLE) && hi_q
                          && (idx_q == count_q - 8'd1);

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            state_q       <= HUNT_A;
            hi_q          <= 1'b0;
            idx_q         <= '0;
            summary_valid <= 1'b0;
            alert_valid   <= 1'b0;
        end else begin
            summary_valid <= last_sample;
            alert_valid   <= last_sample;
            if (rx_valid) begin
                case (state_q)
                    HUNT_A: begin
                        if (rx_byte == `SCAN_HEADER_A) begin
                            state_q <= HUNT_B;
                        end
                    end
                    // anything but the second header byte restarts the hunt
                    HUNT_B: state_q <= (rx_byte == `SCAN_HEADER_B) ? GET_COUNT : HUNT_A;
                    GET_COUNT: begin
                        state_q <= GET_FSA;
                        hi_q    <= 1'b0;
                        idx_q   <= '0;
                    end
                    GET_FSA: begin
                        hi_q <= ~hi_q;
                        if (hi_q) begin
                            state_q <= GET_LSA;
                        end
                    end
                    GET_LSA: begin
                        hi_q <= ~hi_q;
                        if (hi_q) begin
                            state_q <= GET_SAMPLE;
                        end
                    end
                    GET_SAMPLE: begin
                        hi_q <= ~hi_q;
                        // zero samples still advance the index
                        if (hi_q) begin
                            idx_q <= idx_q + 8'd1;
                        end
                        if (last_sample) begin
                            state_q <= HUNT_A;
                        end
                    end
                    default: state_q <= HUNT_A;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (!hi_q) begin
                lo_q <= rx_byte;
            end
            case (state_q)
                GET_COUNT: begin
                    // fresh trackers for every packet
                    count_q   <= rx_byte;
                    min_q     <= '1;
                    max_q     <= '0;
                    min_idx_q <= '0;
                    max_idx_q <= '0;
                    mask_q    <= '0;
                end
                GET_FSA: begin
                    if (hi_q) begin
                        fsa_q <= word;
                    end
                end
                GET_LSA: begin
                    if (hi_q) begin
                        lsa_q <= word;
                    end
                end
                GET_SAMPLE: begin
                    if (hi_q) begin
                        if (take_min) begin
                            min_q <= word;
                        end
                        if (take_max) begin
                            max_q <= word;
                        end
                        min_idx_q <= min_idx_next;
                        max_idx_q <= max_idx_next;
                        mask_q    <= mask_next;
                    end
                end
                default: ;
            endcase
        end
        // publish including the last sample's update
        if (last_sample) begin
            summary.fsa     <= fsa_q;
            summary.lsa     <= lsa_q;
            summary.count   <= count_q;
            summary.min_idx <= min_idx_next;
            summary.max_idx <= max_idx_next;
            alert           <= mask_next;
        end
    end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`include "scan_cfg.svh"
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       TxD_reset,
    input  logic       rx_serial,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int FULL = `SCAN_CLKS_PER_BIT;
    localparam int HALF = FULL / 2;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state_q;
    logic [1:0] sync_q;
    logic [9:0] cnt_q;
    logic [2:0] bit_q;
    logic [7:0] shift_q;
    logic       bit_tick;
    logic       half_tick;

    // synchronized line is sync_q[1]
    assign half_tick = (cnt_q == 10'(HALF - 1));
    assign bit_tick  = (cnt_q == 10'(FULL - 1));
    assign rx_byte   = shift_q;

    always_ff @(posedge clk) begin
        if (TxD_reset) begin
            sync_q   <= 2'b11;
            state_q  <= RX_IDLE;
            cnt_q    <= '0;
            bit_q    <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], rx_serial};
            rx_valid <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    // falling edge marks a start bit
                    if (!sync_q[1]) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_tick) begin
                        cnt_q <= '0;
                        bit_q <= '0;
                        // glitch filter, start must still be low at mid-bit
                        state_q <= sync_q[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 10'd1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 3'd1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 10'd1;
                    end
                end
                default: begin
                    if (bit_tick) begin
                        cnt_q   <= '0;
                        state_q <= RX_IDLE;
                        // framing error drops the byte
                        rx_valid <= sync_q[1];
                    end else begin
                        cnt_q <= cnt_q + 10'd1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && bit_tick) begin
            shift_q <= {sync_q[1], shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== scan_pkg.sv ====
`default_nettype none

package scan_pkg;

    // one distance sample from the sensor
    typedef logic [15:0] distance_t;

    // angle in raw sensor units
    typedef logic [15:0] angle_t;

    // per-packet result of the parser
    typedef struct packed {
        angle_t      fsa;
        angle_t      lsa;
        logic [7:0]  count;
        logic [7:0]  min_idx;
        logic [7:0]  max_idx;
    } scan_summary_t;

    // what goes back out on the uart, alert first
    typedef struct packed {
        logic [15:0] alert;
        angle_t      min_angle;
        angle_t      max_angle;
    } scan_report_t;

endpackage

`default_nettype wire

// ==== scan_cfg.svh ====
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

`default_nettype none

// sync header of every scan packet
`define SCAN_HEADER_A 8'hAA
`define SCAN_HEADER_B 8'h55

// clocks per uart bit, 868 gives 115200 baud at 100 MHz
`define SCAN_CLKS_PER_BIT 16

// samples closer than this count as obstacles
`define SCAN_OBS_DISTANCE 16'h0080
// only the first samples of a packet feed the mask
`define SCAN_ALERT_SAMPLES 16

// divider operand width
`define SCAN_DIV_WIDTH 32

`default_nettype wire

`endif
